// ==== logic/ahb2apb_bridge.sv ====
`include "apb_ss_cfg.svh"
`default_nettype none

module ahb2apb_bridge (
  input  wire logic                      i_tb_hclk5,
  input  wire logic                      i_hresetn5,
  input  wire apb_ss_pkg::ahb_req_t      i_ahb,
  input  wire logic [`APB_SS_DATA_W-1:0] i_hwdata,
  input  wire logic [`APB_SS_DATA_W-1:0] i_gpio_prdata,
  input  wire logic [`APB_SS_DATA_W-1:0] i_ttc_prdata,
  output logic      [`APB_SS_DATA_W-1:0] o_hrdata,
  output logic                           o_hready,
  output apb_ss_pkg::hresp_e             o_hresp,
  output apb_ss_pkg::apb_req_t           o_apb,
  output logic                           o_gpio_psel,
  output logic                           o_ttc_psel
);

  localparam int addr_w = `APB_SS_ADDR_W;
  localparam int data_w = `APB_SS_DATA_W;
  localparam int offs_w = `APB_SS_OFFS_W;

  localparam logic [addr_w-1:0] gpio_base = `APB_SS_GPIO_BASE;
  localparam logic [addr_w-1:0] ttc_base  = `APB_SS_TTC_BASE;

  apb_ss_pkg::bridge_state_e state_q;
  apb_ss_pkg::bridge_state_e state_d;

  logic              accept;       // Address phase taken this edge
  logic              hit_gpio;
  logic              hit_ttc;
  logic              size_ok;
  logic              good;         // Mapped and word sized

  logic [offs_w-1:0] addr_q;
  logic              write_q;
  logic              sel_gpio_q;
  logic              sel_ttc_q;
  logic [data_w-1:0] wdata_q;
  logic [data_w-1:0] rdata_q;

  // ====================================================================
  // Address phase decode
  // ====================================================================
  assign accept   = i_ahb.hsel && o_hready &&
                    (i_ahb.htrans == apb_ss_pkg::NONSEQ ||
                     i_ahb.htrans == apb_ss_pkg::SEQ);
  assign hit_gpio = i_ahb.haddr[addr_w-1:offs_w] == gpio_base[addr_w-1:offs_w];
  assign hit_ttc  = i_ahb.haddr[addr_w-1:offs_w] == ttc_base[addr_w-1:offs_w];
  assign size_ok  = i_ahb.hsize == apb_ss_pkg::WORD;
  assign good     = (hit_gpio || hit_ttc) && size_ok;

  // Peripheral picked for the data phase
  always_ff @(posedge i_tb_hclk5) begin
    if (!i_hresetn5) begin
      sel_gpio_q <= 1'b0;
      sel_ttc_q  <= 1'b0;
    end else if (accept) begin
      sel_gpio_q <= hit_gpio && size_ok;
      sel_ttc_q  <= hit_ttc && size_ok;
    end
  end

  // Offset and direction of the transfer in the data phase
  always_ff @(posedge i_tb_hclk5) begin
    if (accept) begin
      addr_q  <= i_ahb.haddr[offs_w-1:0];
      write_q <= i_ahb.hwrite;
    end
  end

  // ====================================================================
  // FSM
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      apb_ss_pkg::ST_IDLE,
      apb_ss_pkg::ST_ERR2: begin                  // HREADY high in both
        if (accept) begin
          state_d = good ? apb_ss_pkg::ST_SETUP : apb_ss_pkg::ST_ERR1;
        end else begin
          state_d = apb_ss_pkg::ST_IDLE;
        end
      end
      apb_ss_pkg::ST_SETUP:  state_d = apb_ss_pkg::ST_ACCESS;
      apb_ss_pkg::ST_ACCESS: state_d = apb_ss_pkg::ST_IDLE;
      apb_ss_pkg::ST_ERR1:   state_d = apb_ss_pkg::ST_ERR2;
      default:               state_d = apb_ss_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_tb_hclk5) begin
    if (!i_hresetn5) begin
      state_q <= apb_ss_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Write data held by the master, sampled in the first data cycle
  always_ff @(posedge i_tb_hclk5) begin
    if (state_q == apb_ss_pkg::ST_SETUP) begin
      wdata_q <= i_hwdata;
    end
  end

  // Read return, muxed by the registered select at end of ACCESS
  always_ff @(posedge i_tb_hclk5) begin
    if (state_q == apb_ss_pkg::ST_ACCESS && !write_q) begin
      if (sel_gpio_q) begin
        rdata_q <= i_gpio_prdata;
      end else if (sel_ttc_q) begin
        rdata_q <= i_ttc_prdata;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  // ====================================================================
  // Outputs
  // ====================================================================
  always_comb begin
    o_apb.paddr   = addr_q;
    o_apb.pwrite  = write_q;
    o_apb.pwdata  = wdata_q;
    o_apb.penable = state_q == apb_ss_pkg::ST_ACCESS;  // Second APB cycle
  end

  assign o_gpio_psel = sel_gpio_q && (state_q == apb_ss_pkg::ST_SETUP ||
                                      state_q == apb_ss_pkg::ST_ACCESS);
  assign o_ttc_psel  = sel_ttc_q && (state_q == apb_ss_pkg::ST_SETUP ||
                                     state_q == apb_ss_pkg::ST_ACCESS);

  assign o_hready = state_q == apb_ss_pkg::ST_IDLE || state_q == apb_ss_pkg::ST_ERR2;
  assign o_hresp  = (state_q == apb_ss_pkg::ST_ERR1 || state_q == apb_ss_pkg::ST_ERR2) ?
                    apb_ss_pkg::ERROR : apb_ss_pkg::OKAY;
  assign o_hrdata = rdata_q;

endmodule

`default_nettype wire

// ==== logic/apb_ss_cfg.svh ====
`ifndef APB_SS_CFG_SVH
`define APB_SS_CFG_SVH
`default_nettype none

// Bus widths
`define APB_SS_ADDR_W      32
`define APB_SS_DATA_W      32
`define APB_SS_OFFS_W      8          // Offset bits inside one 256 byte window
`define APB_SS_GPIO_W      16

// Peripheral windows, address bits above bit 7 pick the window
`define APB_SS_GPIO_BASE   32'h0000_0000
`define APB_SS_TTC_BASE    32'h0000_0100

// GPIO register offsets
`define APB_SS_GPIO_DOUT   8'h00
`define APB_SS_GPIO_OE     8'h04
`define APB_SS_GPIO_DIN    8'h08      // Read only
`define APB_SS_GPIO_IEN    8'h0C
`define APB_SS_GPIO_ISTAT  8'h10      // Write one to clear

// Timer register offsets
`define APB_SS_TTC_LOAD    8'h00
`define APB_SS_TTC_CTRL    8'h04      // Bit 0 enable, bit 1 periodic
`define APB_SS_TTC_COUNT   8'h08      // Read only
`define APB_SS_TTC_STAT    8'h0C      // Write one to clear
`define APB_SS_TTC_DIV     8          // Clock cycles per timer tick

`default_nettype wire
`endif

// ==== logic/apb_ss_pkg.sv ====
`include "apb_ss_cfg.svh"
`default_nettype none

package apb_ss_pkg;

  // ====================================================================
  // AHB-Lite encodings
  // ====================================================================
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,                    // First beat of a transfer
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010                      // Only size the bridge accepts
  } hsize_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Bridge FSM
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,                  // HREADY high, waiting for a transfer
    ST_SETUP  = 3'd1,                  // APB select phase
    ST_ACCESS = 3'd2,                  // APB enable phase
    ST_ERR1   = 3'd3,                  // ERROR with HREADY low
    ST_ERR2   = 3'd4                   // ERROR with HREADY high
  } bridge_state_e;

  // ====================================================================
  // Grouped bus signals
  // ====================================================================
  typedef struct packed {
    htrans_e                   htrans;
    hsize_e                    hsize;
    logic                      hwrite;
    logic [`APB_SS_ADDR_W-1:0] haddr;
    logic                      hsel;
  } ahb_req_t;

  // Shared by both peripherals, select travels apart
  typedef struct packed {
    logic [`APB_SS_OFFS_W-1:0] paddr;  // Offset inside the window
    logic                      pwrite;
    logic [`APB_SS_DATA_W-1:0] pwdata;
    logic                      penable;
  } apb_req_t;

endpackage

`default_nettype wire

// ==== logic/apb_ss_top.sv ====
`include "apb_ss_cfg.svh"
`default_nettype none

module apb_ss_top (
  input  wire logic                      i_tb_hclk5,
  input  wire logic                      i_hresetn5,
  input  wire apb_ss_pkg::ahb_req_t      i_ahb,
  input  wire logic [`APB_SS_DATA_W-1:0] i_hwdata,
  input  wire logic [`APB_SS_GPIO_W-1:0] i_gpio_in,
  output logic      [`APB_SS_DATA_W-1:0] o_hrdata,
  output logic                           o_hready,
  output apb_ss_pkg::hresp_e             o_hresp,
  output logic      [`APB_SS_GPIO_W-1:0] o_gpio_out,
  output logic      [`APB_SS_GPIO_W-1:0] o_gpio_oe,
  output logic                           o_gpio_irq,
  output logic                           o_ttc_irq
);

  // ====================================================================
  // APB side wires
  // ====================================================================
  apb_ss_pkg::apb_req_t        apb;           // Shared request to both slaves
  logic                        gpio_psel;
  logic                        ttc_psel;
  logic [`APB_SS_DATA_W-1:0]   gpio_prdata;
  logic [`APB_SS_DATA_W-1:0]   ttc_prdata;

  ahb2apb_bridge u_bridge (
    .i_tb_hclk5    (i_tb_hclk5),
    .i_hresetn5    (i_hresetn5),
    .i_ahb         (i_ahb),
    .i_hwdata      (i_hwdata),
    .i_gpio_prdata (gpio_prdata),
    .i_ttc_prdata  (ttc_prdata),
    .o_hrdata      (o_hrdata),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp),
    .o_apb         (apb),
    .o_gpio_psel   (gpio_psel),
    .o_ttc_psel    (ttc_psel)
  );

  gpio_apb u_gpio (
    .i_tb_hclk5 (i_tb_hclk5),
    .i_hresetn5 (i_hresetn5),
    .i_apb      (apb),
    .i_psel     (gpio_psel),
    .i_gpio_in  (i_gpio_in),               // Raw pins, synchronized inside
    .o_prdata   (gpio_prdata),
    .o_gpio_out (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe),
    .o_gpio_irq (o_gpio_irq)
  );

  ttc_apb u_ttc (
    .i_tb_hclk5 (i_tb_hclk5),
    .i_hresetn5 (i_hresetn5),
    .i_apb      (apb),
    .i_psel     (ttc_psel),
    .o_prdata   (ttc_prdata),
    .o_ttc_irq  (o_ttc_irq)
  );

endmodule

`default_nettype wire

// ==== logic/gpio_apb.sv ====
`include "apb_ss_cfg.svh"
`default_nettype none

module gpio_apb (
  input  wire logic                      i_tb_hclk5,
  input  wire logic                      i_hresetn5,
  input  wire apb_ss_pkg::apb_req_t      i_apb,
  input  wire logic                      i_psel,
  input  wire logic [`APB_SS_GPIO_W-1:0] i_gpio_in,
  output logic      [`APB_SS_DATA_W-1:0] o_prdata,
  output logic      [`APB_SS_GPIO_W-1:0] o_gpio_out,
  output logic      [`APB_SS_GPIO_W-1:0] o_gpio_oe,
  output logic                           o_gpio_irq
);

  localparam int gpio_w = `APB_SS_GPIO_W;

  logic [gpio_w-1:0] dout_q;
  logic [gpio_w-1:0] oe_q;
  logic [gpio_w-1:0] ien_q;
  logic [gpio_w-1:0] istat_q;
  logic [gpio_w-1:0] sync1_q;      // First metastability flop
  logic [gpio_w-1:0] sync2_q;      // Seen as DIN
  logic [gpio_w-1:0] prev_q;       // Last synchronized value
  logic [gpio_w-1:0] rise;
  logic [gpio_w-1:0] clr;
  logic              wr_en;

  // Writes land in the enable phase only
  assign wr_en = i_psel && i_apb.penable && i_apb.pwrite;
  assign rise  = sync2_q & ~prev_q;
  assign clr   = (wr_en && i_apb.paddr == `APB_SS_GPIO_ISTAT) ?
                 i_apb.pwdata[gpio_w-1:0] : '0;

  always_ff @(posedge i_tb_hclk5) begin
    if (!i_hresetn5) begin
      dout_q  <= '0;
      oe_q    <= '0;
      ien_q   <= '0;
      istat_q <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      istat_q <= (istat_q & ~clr) | rise;         // A new edge beats the clear
      if (wr_en) begin
        case (i_apb.paddr)
          `APB_SS_GPIO_DOUT: dout_q <= i_apb.pwdata[gpio_w-1:0];
          `APB_SS_GPIO_OE:   oe_q   <= i_apb.pwdata[gpio_w-1:0];
          `APB_SS_GPIO_IEN:  ien_q  <= i_apb.pwdata[gpio_w-1:0];
          default: ;                              // DIN, ISTAT and holes
        endcase
      end
    end
  end

  // Read mux, holes read zero
  always_comb begin
    o_prdata = '0;
    case (i_apb.paddr)
      `APB_SS_GPIO_DOUT:  o_prdata[gpio_w-1:0] = dout_q;
      `APB_SS_GPIO_OE:    o_prdata[gpio_w-1:0] = oe_q;
      `APB_SS_GPIO_DIN:   o_prdata[gpio_w-1:0] = sync2_q;
      `APB_SS_GPIO_IEN:   o_prdata[gpio_w-1:0] = ien_q;
      `APB_SS_GPIO_ISTAT: o_prdata[gpio_w-1:0] = istat_q;
      default: ;
    endcase
  end

  assign o_gpio_out = dout_q;
  assign o_gpio_oe  = oe_q;
  assign o_gpio_irq = |(istat_q & ien_q);        // Masked level

endmodule

`default_nettype wire

// ==== logic/ttc_apb.sv ====
`include "apb_ss_cfg.svh"
`default_nettype none

module ttc_apb (
  input  wire logic                      i_tb_hclk5,
  input  wire logic                      i_hresetn5,
  input  wire apb_ss_pkg::apb_req_t      i_apb,
  input  wire logic                      i_psel,
  output logic      [`APB_SS_DATA_W-1:0] o_prdata,
  output logic                           o_ttc_irq
);

  localparam int data_w = `APB_SS_DATA_W;
  localparam int div_w  = (`APB_SS_TTC_DIV > 1) ? $clog2(`APB_SS_TTC_DIV) : 1;

  logic [data_w-1:0] load_q;
  logic [data_w-1:0] count_q;
  logic              en_q;         // CTRL bit 0
  logic              periodic_q;   // CTRL bit 1
  logic              stat_q;       // Sticky expiry flag
  logic [div_w-1:0]  div_cnt_q;
  logic              tick;
  logic              expire;
  logic              wr_en;
  logic              stat_clr;

  assign wr_en    = i_psel && i_apb.penable && i_apb.pwrite;
  assign tick     = en_q && (div_cnt_q == div_w'(`APB_SS_TTC_DIV - 1));
  assign expire   = tick && (count_q <= data_w'(1));     // Count reaches zero
  assign stat_clr = wr_en && i_apb.paddr == `APB_SS_TTC_STAT && i_apb.pwdata[0];

  // ====================================================================
  // Prescaler and counter
  // ====================================================================
  always_ff @(posedge i_tb_hclk5) begin
    if (!i_hresetn5) begin
      load_q     <= '0;
      count_q    <= '0;
      en_q       <= 1'b0;
      periodic_q <= 1'b0;
      stat_q     <= 1'b0;
      div_cnt_q  <= '0;
    end else begin
      // Held at zero while stopped
      if (!en_q || tick) begin
        div_cnt_q <= '0;
      end else begin
        div_cnt_q <= div_cnt_q + div_w'(1);
      end

      if (expire) begin
        if (periodic_q) begin
          count_q <= load_q;
        end else begin
          count_q <= '0;
          en_q    <= 1'b0;                        // One-shot stops itself
        end
      end else if (tick) begin
        count_q <= count_q - data_w'(1);
      end

      stat_q <= (stat_q && !stat_clr) || expire;  // Expiry wins over clear

      // Bus writes override the counter update
      if (wr_en) begin
        case (i_apb.paddr)
          `APB_SS_TTC_LOAD: begin
            load_q  <= i_apb.pwdata;
            count_q <= i_apb.pwdata;
          end
          `APB_SS_TTC_CTRL: begin
            en_q       <= i_apb.pwdata[0];
            periodic_q <= i_apb.pwdata[1];
          end
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    o_prdata = '0;
    case (i_apb.paddr)
      `APB_SS_TTC_LOAD:  o_prdata      = load_q;
      `APB_SS_TTC_CTRL:  o_prdata[1:0] = {periodic_q, en_q};
      `APB_SS_TTC_COUNT: o_prdata      = count_q;
      `APB_SS_TTC_STAT:  o_prdata[0]   = stat_q;
      default: ;                                  // Holes read zero
    endcase
  end

  assign o_ttc_irq = stat_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module apb_ss_tb -Mdir obj_dir -o apb_ss_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/apb_ss_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim/apb_ss_assert.sv ====
`default_nettype none

module apb_ss_assert (
  input wire logic               i_tb_hclk5,
  input wire logic               i_hresetn5,
  input wire logic               i_penable,
  input wire logic               i_gpio_psel,
  input wire logic               i_ttc_psel,
  input wire logic               i_hready,
  input wire apb_ss_pkg::hresp_e i_hresp
);

  logic sel;      // Any peripheral selected
  logic err;

  assign sel = i_gpio_psel || i_ttc_psel;
  assign err = i_hresp == apb_ss_pkg::ERROR;

  // ====================================================================
  // APB phase order
  // ====================================================================
  a_enable_after_sel: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    i_penable |-> $past(sel && !i_penable)) else $error("PENABLE without a setup cycle");
  a_sel_holds: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    (sel && !i_penable) |=> (sel && i_penable)) else $error("Select dropped before ACCESS");

  // Two wait states per good transfer
  a_wait_setup: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    sel |-> !i_hready) else $error("HREADY high during an APB access");
  a_ready_after: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    (sel && i_penable) |=> i_hready) else $error("HREADY low after ACCESS");
  a_no_stray_wait: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    !i_hready |-> (sel || err)) else $error("HREADY low outside a transfer");

  // Two cycle ERROR response
  a_err_first: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    (err && !i_hready) |=> (err && i_hready)) else $error("ERROR not followed by ready");
  a_err_second: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    (err && i_hready) |-> $past(err && !i_hready)) else $error("ERROR lacks its wait cycle");
  a_err_no_apb: assert property (@(posedge i_tb_hclk5) disable iff (!i_hresetn5)
    err |-> !sel) else $error("APB access during an ERROR response");

endmodule

`default_nettype wire

// ==== sim/apb_ss_tb.sv ====
`include "apb_ss_cfg.svh"
`default_nettype none

module apb_ss_tb;

  localparam int data_w = `APB_SS_DATA_W;
  localparam int addr_w = `APB_SS_ADDR_W;
  localparam int gpio_w = `APB_SS_GPIO_W;
  localparam int div    = `APB_SS_TTC_DIV;
  localparam int n_reg  = 24;                    // Write/read pairs
  localparam int n_err  = 16;
  localparam int n_din  = 16;

  // Run budget, doubled for the timeout
  localparam int xfer_cyc    = 5;
  localparam int n_xfers     = 2 * n_reg + n_err + 4 + n_din + 12 + 8 + 10;
  localparam int wait_cyc    = 10 + 3 * n_din + 15 + 3 * 17 * div;
  localparam int cycle_limit = 2 * (n_xfers * xfer_cyc + wait_cyc);

  localparam logic [data_w-1:0] gpio_mask = data_w'({gpio_w{1'b1}});
  localparam logic [addr_w-1:0] a_dout  = `APB_SS_GPIO_BASE | `APB_SS_GPIO_DOUT;
  localparam logic [addr_w-1:0] a_oe    = `APB_SS_GPIO_BASE | `APB_SS_GPIO_OE;
  localparam logic [addr_w-1:0] a_din   = `APB_SS_GPIO_BASE | `APB_SS_GPIO_DIN;
  localparam logic [addr_w-1:0] a_ien   = `APB_SS_GPIO_BASE | `APB_SS_GPIO_IEN;
  localparam logic [addr_w-1:0] a_istat = `APB_SS_GPIO_BASE | `APB_SS_GPIO_ISTAT;
  localparam logic [addr_w-1:0] a_load  = `APB_SS_TTC_BASE | `APB_SS_TTC_LOAD;
  localparam logic [addr_w-1:0] a_ctrl  = `APB_SS_TTC_BASE | `APB_SS_TTC_CTRL;
  localparam logic [addr_w-1:0] a_count = `APB_SS_TTC_BASE | `APB_SS_TTC_COUNT;
  localparam logic [addr_w-1:0] a_stat  = `APB_SS_TTC_BASE | `APB_SS_TTC_STAT;

  logic                 tb_hclk5;
  logic                 hresetn5;
  apb_ss_pkg::ahb_req_t ahb;
  logic [data_w-1:0]    hwdata;
  logic [gpio_w-1:0]    gpio_in;
  logic [data_w-1:0]    hrdata;
  logic                 hready;
  apb_ss_pkg::hresp_e   hresp;
  logic [gpio_w-1:0]    gpio_out;
  logic [gpio_w-1:0]    gpio_oe;
  logic                 gpio_irq;
  logic                 ttc_irq;

  int seed;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [data_w-1:0] model_regs [4];             // DOUT, OE, IEN, LOAD

  apb_ss_top i_dut (
    .i_tb_hclk5 (tb_hclk5),
    .i_hresetn5 (hresetn5),
    .i_ahb      (ahb),
    .i_hwdata   (hwdata),
    .i_gpio_in  (gpio_in),
    .o_hrdata   (hrdata),
    .o_hready   (hready),
    .o_hresp    (hresp),
    .o_gpio_out (gpio_out),
    .o_gpio_oe  (gpio_oe),
    .o_gpio_irq (gpio_irq),
    .o_ttc_irq  (ttc_irq)
  );

  bind ahb2apb_bridge apb_ss_assert u_assert (
    .i_tb_hclk5  (i_tb_hclk5),
    .i_hresetn5  (i_hresetn5),
    .i_penable   (o_apb.penable),
    .i_gpio_psel (o_gpio_psel),
    .i_ttc_psel  (o_ttc_psel),
    .i_hready    (o_hready),
    .i_hresp     (o_hresp)
  );

  initial begin
    tb_hclk5 = 1'b0;
    forever #4 tb_hclk5 = ~tb_hclk5;
  end

  // Hard stop on a hung run
  always @(posedge tb_hclk5) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input apb_ss_pkg::hresp_e got, input apb_ss_pkg::hresp_e exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ====================================================================
  // Bus and pin helpers
  // ====================================================================
  task automatic bus_xfer(input logic wr, input logic [addr_w-1:0] addr,
                          input apb_ss_pkg::hsize_e sz, input logic [data_w-1:0] wdata,
                          output logic [data_w-1:0] rdata, output apb_ss_pkg::hresp_e resp);
    apb_ss_pkg::ahb_req_t req;
    int waits;
    req.hsel   = 1'b1;
    req.htrans = apb_ss_pkg::NONSEQ;
    req.hsize  = sz;
    req.hwrite = wr;
    req.haddr  = addr;
    @(posedge tb_hclk5);
    ahb <= req;                                  // Address phase
    @(posedge tb_hclk5);
    ahb    <= '0;
    hwdata <= wdata;                             // Data phase
    waits = 0;
    @(negedge tb_hclk5);
    while (!hready && waits < 8) begin
      waits++;
      @(negedge tb_hclk5);
    end
    if (!hready) begin
      errors++;
      $display("Bus stall: o_hready stayed low at time %0t", $time);
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic [data_w-1:0] rd;
    apb_ss_pkg::hresp_e resp;
    bus_xfer(1'b1, addr, apb_ss_pkg::WORD, data, rd, resp);
    check_resp(resp, apb_ss_pkg::OKAY, "write response");
  endtask

  task automatic read_check(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp,
                            input string what);
    logic [data_w-1:0] rd;
    apb_ss_pkg::hresp_e resp;
    bus_xfer(1'b0, addr, apb_ss_pkg::WORD, '0, rd, resp);
    check_resp(resp, apb_ss_pkg::OKAY, "read response");
    check_word(rd, exp, what);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge tb_hclk5);
  endtask

  task automatic drive_pins(input logic [gpio_w-1:0] v);
    @(posedge tb_hclk5);
    gpio_in <= v;
  endtask

  // Poll the timer level, bounded
  task automatic wait_ttc_irq(input int limit);
    int n;
    n = 0;
    while (!ttc_irq && n < limit) begin
      @(negedge tb_hclk5);
      n++;
    end
  endtask

  function automatic logic [addr_w-1:0] reg_addr(input int idx);
    case (idx)
      0:       reg_addr = a_dout;
      1:       reg_addr = a_oe;
      2:       reg_addr = a_ien;
      default: reg_addr = a_load;
    endcase
  endfunction

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    int k;
    int p;
    int q;
    int n;
    logic wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] rdata;
    logic [gpio_w-1:0] din;
    apb_ss_pkg::hsize_e sz;
    apb_ss_pkg::hresp_e resp;

    seed     = 74;
    hresetn5 = 1'b0;
    ahb      = '0;
    hwdata   = '0;
    gpio_in  = '0;
    for (int i = 0; i < 4; i++) model_regs[i] = '0;
    repeat (2) @(posedge tb_hclk5);
    hresetn5 <= 1'b1;
    @(negedge tb_hclk5);
    check_irq(hready, 1'b1, "o_hready after reset");
    check_resp(hresp, apb_ss_pkg::OKAY, "o_hresp after reset");
    check_word(data_w'(gpio_oe), '0, "o_gpio_oe after reset");
    check_irq(gpio_irq, 1'b0, "o_gpio_irq after reset");
    check_irq(ttc_irq, 1'b0, "o_ttc_irq after reset");

    // Random register traffic
    repeat (n_reg) begin
      k     = {$random(seed)} % 4;
      wdata = $random(seed);
      model_regs[k] = (k < 3) ? (wdata & gpio_mask) : wdata;
      write_reg(reg_addr(k), wdata);
      check_word(data_w'(gpio_out), model_regs[0], "o_gpio_out");
      check_word(data_w'(gpio_oe), model_regs[1], "o_gpio_oe");
      read_check(reg_addr(k), model_regs[k], "register read-back");
    end

    // Bad windows and sizes, no side effects
    repeat (n_err) begin
      if ({$random(seed)} % 2 == 0) begin
        addr = ($random(seed) | 32'h0000_0200) & ~32'h3;   // Above both windows
        sz   = apb_ss_pkg::WORD;
      end else begin
        addr = reg_addr({$random(seed)} % 4);
        sz   = ({$random(seed)} % 2 == 0) ? apb_ss_pkg::BYTE : apb_ss_pkg::HALF;
      end
      wr    = ({$random(seed)} % 2) == 1;
      wdata = $random(seed);
      bus_xfer(wr, addr, sz, wdata, rdata, resp);
      check_resp(resp, apb_ss_pkg::ERROR, "bad access response");
    end
    for (int i = 0; i < 4; i++) read_check(reg_addr(i), model_regs[i], "read-back after ERROR");

    // Pin sampling through DIN
    repeat (n_din) begin
      din = gpio_w'($random(seed));
      drive_pins(din);
      idle_cycles(3);
      read_check(a_din, data_w'(din), "DIN");
    end

    // Edge interrupt, start from a quiet state
    write_reg(a_ien, '0);
    model_regs[2] = '0;
    drive_pins('0);
    idle_cycles(5);
    write_reg(a_istat, gpio_mask);
    read_check(a_istat, '0, "ISTAT after clear");
    p = {$random(seed)} % gpio_w;
    q = (p + 1 + {$random(seed)} % (gpio_w - 1)) % gpio_w;   // Any other pin
    model_regs[2] = data_w'(16'd1 << p);
    write_reg(a_ien, model_regs[2]);
    drive_pins(16'd1 << p);
    idle_cycles(5);
    check_irq(gpio_irq, 1'b1, "o_gpio_irq on enabled edge");
    read_check(a_istat, data_w'(16'd1 << p), "ISTAT enabled pin");
    write_reg(a_istat, data_w'(16'd1 << p));
    check_irq(gpio_irq, 1'b0, "o_gpio_irq after clear");
    read_check(a_istat, '0, "ISTAT after one clear");
    drive_pins((16'd1 << p) | (16'd1 << q));
    idle_cycles(5);
    read_check(a_istat, data_w'(16'd1 << q), "ISTAT masked pin");
    check_irq(gpio_irq, 1'b0, "o_gpio_irq masked pin");

    // One-shot timer
    n = 1 + {$random(seed)} % 15;
    model_regs[3] = n;
    write_reg(a_load, model_regs[3]);
    write_reg(a_ctrl, 32'h1);
    idle_cycles((n + 2) * div);
    read_check(a_stat, 32'h1, "STAT one-shot");
    check_irq(ttc_irq, 1'b1, "o_ttc_irq one-shot");
    read_check(a_ctrl, '0, "CTRL after one-shot");
    read_check(a_count, '0, "COUNT after one-shot");
    write_reg(a_stat, 32'h1);
    check_irq(ttc_irq, 1'b0, "o_ttc_irq after clear");

    // Periodic timer keeps running
    n = 2 + {$random(seed)} % 14;
    model_regs[3] = n;
    write_reg(a_load, model_regs[3]);
    write_reg(a_ctrl, 32'h3);
    wait_ttc_irq((n + 2) * div);
    check_irq(ttc_irq, 1'b1, "o_ttc_irq first period");
    write_reg(a_stat, 32'h1);
    check_irq(ttc_irq, 1'b0, "o_ttc_irq periodic clear");
    read_check(a_ctrl, 32'h3, "CTRL periodic");
    wait_ttc_irq((n + 2) * div);
    check_irq(ttc_irq, 1'b1, "o_ttc_irq second period");
    read_check(a_stat, 32'h1, "STAT periodic");
    write_reg(a_ctrl, '0);
    write_reg(a_stat, 32'h1);

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/apb_ss_pkg.sv
logic/ahb2apb_bridge.sv
logic/gpio_apb.sv
logic/ttc_apb.sv
logic/apb_ss_top.sv
sim/apb_ss_assert.sv
sim/apb_ss_tb.sv
